/* hdl/cpu_isa_pkg.sv */
// cpu isa package: word and address types, opcodes, instruction layout and program load
package cpu_isa_pkg;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 8;
    localparam int MEM_DEPTH = 2 ** ADDR_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // 7 and F are unused and execute as no-ops
    typedef enum logic [3:0] {
        OP_NOARG = 4'h0,
        OP_LDW   = 4'h1,
        OP_STW   = 4'h2,
        OP_ADD   = 4'h3,
        OP_ADC   = 4'h4,
        OP_SUB   = 4'h5,
        OP_SBB   = 4'h6,
        OP_AND   = 4'h8,
        OP_OR    = 4'h9,
        OP_XOR   = 4'hA,
        OP_JMP   = 4'hB,
        OP_JPZ   = 4'hC,
        OP_JPC   = 4'hD,
        OP_JPS   = 4'hE
    } opcode_e;

    typedef enum logic [3:0] {
        NA_NOP = 4'h0,
        NA_INC = 4'h1,
        NA_DEC = 4'h2,
        NA_NOT = 4'h5,
        NA_COM = 4'h6,
        NA_MWO = 4'h9,
        NA_MIW = 4'hA,
        NA_CLW = 4'hB,
        NA_CLO = 4'hC
    } noarg_e;

    // bit group codes within a no-argument word
    localparam logic [2:0] BITGRP_NONE = 3'b000;
    localparam logic [2:0] BITGRP_BOS  = 3'b100;
    localparam logic [2:0] BITGRP_BOC  = 3'b101;

    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] stack;
        logic [2:0] spare;
        logic [2:0] bit_grp;
        logic [3:0] low;
    } instr_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } prog_write_t;

    // memory-operand opcodes take a second, execute cycle
    function automatic logic needs_operand(opcode_e op);
        case (op)
            OP_LDW, OP_STW, OP_ADD, OP_ADC, OP_SUB, OP_SBB,
            OP_AND, OP_OR, OP_XOR: return 1'b1;
            default:               return 1'b0;
        endcase
    endfunction

endpackage

/* hdl/cpu_ctrl_pkg.sv */
// cpu control package: control word, alu and output operations, status flags
package cpu_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_INC,
        ALU_DEC,
        ALU_NOT,
        ALU_COM,
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_CLR,
        ALU_IN_LOAD
    } alu_op_e;

    typedef enum logic [2:0] {
        OUT_NONE,
        OUT_MOVE,
        OUT_CLEAR_ALL,
        OUT_SET_BIT,
        OUT_CLEAR_BIT
    } out_op_e;

    typedef struct packed {
        logic z;
        logic c;
        logic s;
    } flags_t;

    typedef struct packed {
        logic    ir_load;
        logic    pc_inc;
        logic    pc_load;
        logic    mar_inc;
        logic    mar_load_arg;
        logic    mar_load_pc;
        logic    a_load;
        logic    ram_write;
        alu_op_e alu_op;
        out_op_e out_op;
    } ctrl_word_t;

    // all strobes low, no alu or output operation
    localparam ctrl_word_t CTRL_IDLE = '0;

endpackage

/* hdl/program_ram.sv */
// program ram: word memory with asynchronous read, cpu write and program-load write
`timescale 1ns/1ps

module program_ram (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_isa_pkg::prog_write_t prog,
    input  cpu_isa_pkg::addr_t       addr,
    input  logic                     write,
    input  cpu_isa_pkg::word_t       wdata,
    output cpu_isa_pkg::word_t       rdata
);
    import cpu_isa_pkg::*;

    word_t mem [MEM_DEPTH];

    // program load wins over a cpu store
    always_ff @(posedge clk) begin
        if (prog.en) begin
            mem[prog.addr] <= prog.data;
        end else if (write && !reset) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

    // loader may only write while the cpu is held
    prog_only_in_reset: assert property (@(posedge clk) prog.en |-> reset)
        else $error("program-load write with reset low");

endmodule

/* hdl/address_unit.sv */
// address unit: program counter and memory address register for fetch and operand access
`timescale 1ns/1ps

module address_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_ctrl_pkg::ctrl_word_t ctrl,
    input  cpu_isa_pkg::word_t       rdata,
    output cpu_isa_pkg::addr_t       mem_addr
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    addr_t pc;
    addr_t mar;
    addr_t arg;

    // argument of the word currently on the read port
    assign arg = rdata[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= arg;
        end else if (ctrl.pc_inc) begin
            pc <= pc + addr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mar <= '0;
        end else if (ctrl.mar_load_arg) begin
            mar <= arg;
        end else if (ctrl.mar_load_pc) begin
            // back to the next instruction after an operand cycle
            mar <= pc;
        end else if (ctrl.mar_inc) begin
            mar <= mar + addr_t'(1);
        end
    end

    assign mem_addr = mar;

    mar_single_source: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.mar_load_arg, ctrl.mar_load_pc, ctrl.mar_inc}))
        else $error("more than one mar source active");

endmodule

/* hdl/accumulator_alu.sv */
// accumulator alu: A register, carry flag, arithmetic and logic operations, status flags
`timescale 1ns/1ps

module accumulator_alu (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_ctrl_pkg::ctrl_word_t ctrl,
    input  cpu_isa_pkg::word_t       rdata,
    input  cpu_isa_pkg::word_t       in,
    output cpu_isa_pkg::word_t       a,
    output cpu_ctrl_pkg::flags_t     flags
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t             a_q;
    logic              carry;
    word_t             a_next;
    logic              c_next;
    logic [WORD_W:0]   a_ext;
    logic [WORD_W:0]   b_ext;
    logic [WORD_W:0]   cin_ext;
    word_t             cin_w;

    // 17-bit views for carry-out and borrow compares
    assign a_ext   = {1'b0, a_q};
    assign b_ext   = {1'b0, rdata};
    assign cin_ext = {{WORD_W{1'b0}}, carry};
    assign cin_w   = {{(WORD_W-1){1'b0}}, carry};

    always_comb begin
        a_next = a_q;
        c_next = carry;
        case (ctrl.alu_op)
            ALU_INC:     {c_next, a_next} = a_ext + {{WORD_W{1'b0}}, 1'b1};
            ALU_DEC: begin
                c_next = (a_q == '0);
                a_next = a_q - word_t'(1);
            end
            ALU_NOT:     a_next = ~a_q;
            ALU_COM:     a_next = ~a_q + word_t'(1);
            ALU_ADD:     {c_next, a_next} = a_ext + b_ext;
            ALU_ADC:     {c_next, a_next} = a_ext + b_ext + cin_ext;
            ALU_SUB: begin
                c_next = (a_q < rdata);
                a_next = a_q - rdata;
            end
            ALU_SBB: begin
                // borrow compare needs the 17th bit when rdata is all ones
                c_next = (a_ext < (b_ext + cin_ext));
                a_next = a_q - rdata - cin_w;
            end
            ALU_AND:     a_next = a_q & rdata;
            ALU_OR:      a_next = a_q | rdata;
            ALU_XOR:     a_next = a_q ^ rdata;
            ALU_CLR:     a_next = '0;
            ALU_IN_LOAD: a_next = in;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a_q   <= '0;
            carry <= 1'b0;
        end else if (ctrl.a_load) begin
            a_q <= rdata;
        end else begin
            a_q   <= a_next;
            carry <= c_next;
        end
    end

    assign a       = a_q;
    assign flags.z = (a_q == '0);
    assign flags.c = carry;
    assign flags.s = a_q[WORD_W-1];

endmodule

/* hdl/controller.sv */
// controller: fetch/execute sequencer and instruction decoder driving the control word
`timescale 1ns/1ps

module controller (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_isa_pkg::word_t       rdata,
    input  cpu_ctrl_pkg::flags_t     flags,
    output cpu_ctrl_pkg::ctrl_word_t ctrl
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic   exec_stage;
    instr_t ir;
    instr_t fetch_ins;
    logic   jump_taken;

    assign fetch_ins = instr_t'(rdata);

    always_comb begin
        case (fetch_ins.opcode)
            OP_JMP:  jump_taken = 1'b1;
            OP_JPZ:  jump_taken = flags.z;
            OP_JPC:  jump_taken = flags.c;
            OP_JPS:  jump_taken = flags.s;
            default: jump_taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = CTRL_IDLE;
        if (!exec_stage) begin
            if (needs_operand(fetch_ins.opcode)) begin
                ctrl.ir_load      = 1'b1;
                ctrl.pc_inc       = 1'b1;
                ctrl.mar_load_arg = 1'b1;
            end else if (jump_taken) begin
                ctrl.pc_load      = 1'b1;
                ctrl.mar_load_arg = 1'b1;
            end else begin
                ctrl.pc_inc  = 1'b1;
                ctrl.mar_inc = 1'b1;
                // nonzero stack field means a no-op
                if (fetch_ins.opcode == OP_NOARG && fetch_ins.stack == 2'b00) begin
                    case (fetch_ins.bit_grp)
                        BITGRP_BOS: ctrl.out_op = OUT_SET_BIT;
                        BITGRP_BOC: ctrl.out_op = OUT_CLEAR_BIT;
                        BITGRP_NONE: begin
                            case (fetch_ins.low)
                                NA_INC:  ctrl.alu_op = ALU_INC;
                                NA_DEC:  ctrl.alu_op = ALU_DEC;
                                NA_NOT:  ctrl.alu_op = ALU_NOT;
                                NA_COM:  ctrl.alu_op = ALU_COM;
                                NA_MWO:  ctrl.out_op = OUT_MOVE;
                                NA_MIW:  ctrl.alu_op = ALU_IN_LOAD;
                                NA_CLW:  ctrl.alu_op = ALU_CLR;
                                NA_CLO:  ctrl.out_op = OUT_CLEAR_ALL;
                                default: ;
                            endcase
                        end
                        default: ;
                    endcase
                end
            end
        end else begin
            // operand cycle, memory sits at MAR
            ctrl.mar_load_pc = 1'b1;
            case (ir.opcode)
                OP_LDW:  ctrl.a_load    = 1'b1;
                OP_STW:  ctrl.ram_write = 1'b1;
                OP_ADD:  ctrl.alu_op    = ALU_ADD;
                OP_ADC:  ctrl.alu_op    = ALU_ADC;
                OP_SUB:  ctrl.alu_op    = ALU_SUB;
                OP_SBB:  ctrl.alu_op    = ALU_SBB;
                OP_AND:  ctrl.alu_op    = ALU_AND;
                OP_OR:   ctrl.alu_op    = ALU_OR;
                OP_XOR:  ctrl.alu_op    = ALU_XOR;
                default: ;
            endcase
        end
    end

    // ir_load is only raised in fetch, so this alternates
    always_ff @(posedge clk) begin
        if (reset) begin
            exec_stage <= 1'b0;
        end else begin
            exec_stage <= ctrl.ir_load;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_load) begin
            ir <= fetch_ins;
        end
    end

    exec_has_operand_op: assert property (@(posedge clk) disable iff (reset)
        exec_stage |-> needs_operand(ir.opcode))
        else $error("execute stage with a one-cycle opcode in IR");

endmodule

/* hdl/output_port.sv */
// output port: output register with move, clear-all, bit-set and bit-clear
`timescale 1ns/1ps

module output_port (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_ctrl_pkg::ctrl_word_t ctrl,
    input  cpu_isa_pkg::word_t       rdata,
    input  cpu_isa_pkg::word_t       a,
    output cpu_isa_pkg::word_t       out
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    instr_t ins;

    // bit number comes from the instruction being fetched
    assign ins = instr_t'(rdata);

    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;
        end else begin
            case (ctrl.out_op)
                OUT_MOVE:      out <= a;
                OUT_CLEAR_ALL: out <= '0;
                OUT_SET_BIT:   out[ins.low] <= 1'b1;
                OUT_CLEAR_BIT: out[ins.low] <= 1'b0;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/accum_cpu.sv */
// accum cpu top: memory, address unit, controller, accumulator and output port
`timescale 1ns/1ps

module accum_cpu (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_isa_pkg::word_t       in,
    input  cpu_isa_pkg::prog_write_t prog,
    output cpu_isa_pkg::word_t       out
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    ctrl_word_t ctrl;
    flags_t     flags;
    word_t      rdata;
    word_t      a;
    addr_t      mem_addr;

    program_ram u_ram (
        .clk   (clk),
        .reset (reset),
        .prog  (prog),
        .addr  (mem_addr),
        .write (ctrl.ram_write),
        .wdata (a),
        .rdata (rdata)
    );

    address_unit u_addr (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .rdata    (rdata),
        .mem_addr (mem_addr)
    );

    controller u_ctrl (
        .clk   (clk),
        .reset (reset),
        .rdata (rdata),
        .flags (flags),
        .ctrl  (ctrl)
    );

    accumulator_alu u_acc (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl),
        .rdata (rdata),
        .in    (in),
        .a     (a),
        .flags (flags)
    );

    output_port u_out (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl),
        .rdata (rdata),
        .a     (a),
        .out   (out)
    );

endmodule

/* include/tb_cpu_model.svh */
// cpu reference model: instruction-set behavior and random program generator for the testbench
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

// LDW and the ALU-with-memory opcodes, then the no-argument accumulator sub-ops
localparam logic [3:0] MEM_OPS [8] = '{4'h1, 4'h3, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9, 4'hA};
localparam logic [3:0] ACC_SUBS [6] = '{4'h1, 4'h2, 4'h5, 4'h6, 4'hA, 4'hB};

word_t img [MEM_DEPTH];
word_t exp_out [$];
int    plen;

// data words sit in the upper half, programs in the lower
function automatic addr_t data_addr();
    return addr_t'(8'h80 | 8'(xorshift()));
endfunction

function automatic void emit(word_t w);
    img[plen] = w;
    plen++;
endfunction

function automatic word_t alu_instr();
    int r;
    r = pick(14);
    if (r < 8) begin
        return {MEM_OPS[r], 4'h0, data_addr()};
    end
    return {12'h000, ACC_SUBS[r - 8]};
endfunction

function automatic word_t bit_instr();
    case (pick(5))
        0, 1: return {12'h004, 4'(pick(16))};
        2, 3: return {12'h005, 4'(pick(16))};
        default: return 16'h000C;
    endcase
endfunction

// any kept opcode, forward jumps only, plus undefined and stack-field no-ops
function automatic word_t any_instr(int i, int n);
    case (pick(9))
        0, 1, 2: return alu_instr();
        3: return {4'h2, 4'h0, data_addr()};
        4: return 16'h0009;
        5: return bit_instr();
        6: return {(4'hB + 4'(pick(4))), 4'h0, addr_t'(i + 1 + pick(n - i))};
        7: return {((pick(2) == 0) ? 4'h7 : 4'hF), 12'(xorshift())};
        default: return {4'h0, 12'(xorshift())};
    endcase
endfunction

function automatic void build_program(int mode);
    int    n;
    addr_t d;
    for (int i = 0; i < MEM_DEPTH; i++) begin
        img[i] = word_t'(xorshift());
    end
    plen = 0;
    n = 4 + pick(12);
    case (mode)
        0: begin
            emit(16'h000A);
            emit(16'h0009);
        end
        1: begin
            d = data_addr();
            emit({4'h1, 4'h0, data_addr()});
            emit(16'h0009);
            emit({4'h2, 4'h0, d});
            emit(16'h000B);
            emit(16'h0009);
            emit({4'h1, 4'h0, d});
            emit(16'h0009);
        end
        2: begin
            repeat (n) begin
                emit(alu_instr());
                emit(16'h0009);
            end
        end
        3: begin
            // jump lands just past the MWO that follows it
            repeat (n) begin
                emit(alu_instr());
                emit({(4'hB + 4'(pick(4))), 4'h0, addr_t'(plen + 2)});
                emit(16'h0009);
            end
        end
        4: begin
            repeat (n) begin
                emit(bit_instr());
            end
        end
        default: begin
            n = 1 + pick(40);
            for (int i = 0; i < n; i++) begin
                emit(any_instr(i, n));
            end
        end
    endcase
    // halt on a jump to itself
    emit({4'hB, 4'h0, addr_t'(plen)});
endfunction

function automatic void predict_outputs(word_t in_val);
    word_t       mem [MEM_DEPTH];
    word_t       a;
    word_t       out_r;
    word_t       w;
    word_t       m;
    word_t       prev;
    logic        c;
    logic [16:0] sum;
    addr_t       pc;
    addr_t       arg;
    mem = img;
    a = '0;
    c = 1'b0;
    out_r = '0;
    pc = '0;
    exp_out.delete();
    for (int step = 0; step < 4096; step++) begin
        w = mem[pc];
        arg = w[7:0];
        m = mem[arg];
        prev = out_r;
        if (w[15:12] == 4'hB && arg == pc) begin
            break;
        end
        pc = pc + addr_t'(1);
        case (w[15:12])
            4'h0: begin
                if (w[11:10] == 2'b00) begin
                    case (w[6:4])
                        3'b100: out_r[w[3:0]] = 1'b1;
                        3'b101: out_r[w[3:0]] = 1'b0;
                        3'b000: begin
                            case (w[3:0])
                                4'h1: {c, a} = {1'b0, a} + 17'd1;
                                4'h2: begin
                                    c = (a == '0);
                                    a = a - 16'd1;
                                end
                                4'h5: a = ~a;
                                4'h6: a = -a;
                                4'h9: out_r = a;
                                4'hA: a = in_val;
                                4'hB: a = '0;
                                4'hC: out_r = '0;
                                default: ;
                            endcase
                        end
                        default: ;
                    endcase
                end
            end
            4'h1: a = m;
            4'h2: mem[arg] = a;
            4'h3: {c, a} = {1'b0, a} + {1'b0, m};
            4'h4: {c, a} = {1'b0, a} + {1'b0, m} + {16'h0, c};
            4'h5: begin
                c = (a < m);
                a = a - m;
            end
            4'h6: begin
                // borrow against operand plus old carry, in 17 bits
                sum = {1'b0, m} + {16'h0, c};
                c = ({1'b0, a} < sum);
                a = word_t'({1'b0, a} - sum);
            end
            4'h8: a = a & m;
            4'h9: a = a | m;
            4'hA: a = a ^ m;
            4'hB: pc = arg;
            4'hC: if (a == '0) pc = arg;
            4'hD: if (c) pc = arg;
            4'hE: if (a[15]) pc = arg;
            default: ;
        endcase
        if (out_r != prev) begin
            exp_out.push_back(out_r);
        end
    end
endfunction

`endif

/* tests/tb_cpu.sv */
// cpu testbench: directed and random programs checked against the instruction-set model
`timescale 1ns/1ps

module tb_cpu;
    import cpu_isa_pkg::*;

    localparam int CHANGE_TIMEOUT = 400;
    localparam int QUIET_CYCLES   = 64;

    logic        clk;
    logic        reset;
    word_t       in;
    prog_write_t prog;
    word_t       out;
    logic [31:0] rng_state;

    accum_cpu uut (
        .clk   (clk),
        .reset (reset),
        .in    (in),
        .prog  (prog),
        .out   (out)
    );

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int pick(int range);
        return int'(xorshift() % 32'(range));
    endfunction

    `include "tb_cpu_model.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(string name, word_t got, word_t want);
        if (got !== want) begin
            $display("error: %s is %h, expected %h", name, got, want);
            abort_run("value mismatch on the DUT output");
        end
    endtask

    task automatic execute_program(int mode);
        word_t in_val;
        word_t last;
        int    waited;
        in_val = word_t'(xorshift());
        build_program(mode);
        predict_outputs(in_val);
        @(posedge clk);
        reset <= 1'b1;
        in    <= in_val;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            @(posedge clk);
            prog <= '{en: 1'b1, addr: addr_t'(i), data: img[i]};
        end
        @(posedge clk);
        prog <= '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("out", out, '0);
        @(posedge clk);
        reset <= 1'b0;
        last = '0;
        foreach (exp_out[k]) begin
            waited = 0;
            @(negedge clk);
            while (out === last) begin
                waited++;
                if (waited > CHANGE_TIMEOUT) begin
                    abort_run("timed out waiting for the next change on out");
                end
                @(negedge clk);
            end
            check_value("out", out, exp_out[k]);
            last = out;
        end
        // program now spins on its halt jump
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (out !== last) begin
                abort_run("out changed after the last expected value");
            end
        end
    endtask

    initial begin
        rng_state = 32'haf6e48ca;
        reset = 1'b1;
        in = '0;
        prog = '0;
        // load, memory, alu, jump and bit-op programs, then long random ones
        for (int mode = 0; mode < 5; mode++) begin
            repeat (10) execute_program(mode);
        end
        repeat (200) execute_program(5);
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/program_ram.sv
hdl/address_unit.sv
hdl/accumulator_alu.sv
hdl/controller.sv
hdl/output_port.sv
hdl/accum_cpu.sv
tests/tb_cpu.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_cpu
RTL_TOP    := accum_cpu
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/tb_cpu_model.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
